// File: all.f
+incdir+verif
verilog/soc_pkg.sv
verilog/addr_decode.sv
verilog/data_ram.sv
verilog/fact_accel.sv
verilog/gpio_port.sv
verilog/seg_display.sv
verilog/soc_top.sv
verif/soc_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build soc_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module soc_tb -Mdir obj_dir -o soc_tb_sim
	./obj_dir/soc_tb_sim > $(LOG); cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/soc_tb_tasks.svh
`ifndef SOC_TB_TASKS_SVH
`define SOC_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Address helpers and bus access
//////////////////////////////////////////////////////////////////////

// Mapped register, {zero, block, zero, offset, byte}
function automatic logic [soc_pkg::ADDR_W-1:0] reg_addr(input logic [3:0] blk,
                                                        input logic [1:0] off);
    return {20'h0, blk, 4'h0, off, 2'b00};
endfunction

// RAM word index to byte address
function automatic logic [soc_pkg::ADDR_W-1:0] ram_addr(input int idx);
    return {24'h0, idx[5:0], 2'b00};
endfunction

// One write strobe cycle, address and data left on the bus
task automatic bus_write(input logic [soc_pkg::ADDR_W-1:0] addr,
                         input logic [soc_pkg::DATA_W-1:0] data);
    @(negedge clk);
    bus.we    = 1'b1;
    bus.addr  = addr;
    bus.wdata = data;
    @(negedge clk);
    bus.we = 1'b0;
endtask

// Readback is combinational, sampled mid low phase
task automatic bus_read(input  logic [soc_pkg::ADDR_W-1:0] addr,
                        output logic [soc_pkg::DATA_W-1:0] data);
    @(negedge clk);
    bus.we   = 1'b0;
    bus.addr = addr;
    #25;
    data = rdata;
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_word(input logic [soc_pkg::DATA_W-1:0] actual,
                          input logic [soc_pkg::DATA_W-1:0] expected,
                          input string                      what);
    if (actual !== expected)
    begin
        error_count++;
        $display("Error at %0t: %s gave %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic check_seg(input logic [7:0] actual,
                         input logic [7:0] expected,
                         input int         digit);
    if (actual !== expected)
    begin
        error_count++;
        $display("Error at %0t: seg on digit %0d is %h, expected %h",
                 $time, digit, actual, expected);
    end
endtask

task automatic read_check(input logic [soc_pkg::ADDR_W-1:0] addr,
                          input logic [soc_pkg::DATA_W-1:0] expected,
                          input string                      what);
    logic [soc_pkg::DATA_W-1:0] got;
    bus_read(addr, got);
    check_word(got, expected, what);
endtask

//////////////////////////////////////////////////////////////////////
// RAM and GPIO
//////////////////////////////////////////////////////////////////////

task automatic test_ram();
    int i;
    for (i = 0; i < soc_pkg::RAM_WORDS; i++)
    begin
        ram_model[i] = $random(seed);
        bus_write(ram_addr(i), ram_model[i]);
    end
    for (i = 0; i < soc_pkg::RAM_WORDS; i++)
    begin
        read_check(ram_addr(i), ram_model[i], $sformatf("RAM word %0d", i));
    end
endtask

task automatic test_gpio();
    logic [31:0] rnd;
    logic [31:0] out1;
    logic [31:0] out2;
    // Inputs change on a falling edge
    @(negedge clk);
    rnd  = $random(seed);
    gpi1 = rnd[7:0];
    gpi2 = rnd[15:8];
    read_check(reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_IN1), {24'h0, rnd[7:0]}, "gpi1 read");
    read_check(reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_IN2), {24'h0, rnd[15:8]}, "gpi2 read");
    out1 = $random(seed);
    out2 = $random(seed);
    bus_write(reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_OUT1), out1);
    bus_write(reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_OUT2), out2);
    check_word(gpo1, out1, "gpo1 pins");
    check_word(gpo2, out2, "gpo2 pins");
    read_check(reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_OUT1), out1, "gpo1 read");
    read_check(reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_OUT2), out2, "gpo2 read");
    // Unused block code and addresses above the 4 KB window
    read_check(32'h0000_0A00, '0, "unmapped block read");
    read_check(32'h0001_0004, '0, "read above window");
    bus_write(32'h0000_0A08, $random(seed));
    // These two alias RAM word 1 and gpo1 in the low bits
    bus_write(32'h0001_0004, $random(seed));
    bus_write(32'h0000_1908, $random(seed));
    read_check(ram_addr(1), ram_model[1], "RAM word 1 after unmapped write");
    check_word(gpo1, out1, "gpo1 after unmapped write");
    check_word(gpo2, out2, "gpo2 after unmapped write");
endtask

//////////////////////////////////////////////////////////////////////
// Factorial accelerator
//////////////////////////////////////////////////////////////////////

function automatic logic [soc_pkg::DATA_W-1:0] factorial(input int n);
    logic [soc_pkg::DATA_W-1:0] f;
    int                         k;
    f = 1;
    for (k = 2; k <= n; k++)
    begin
        f = f * 32'(k);
    end
    return f;
endfunction

// Poll the status register, at most 20 reads
task automatic wait_fact_done(input int n, output logic [soc_pkg::DATA_W-1:0] stat);
    int   polls;
    logic seen;
    polls = 0;
    seen  = 1'b0;
    stat  = '0;
    while (!seen && polls < 20)
    begin
        bus_read(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_STAT), stat);
        seen = stat[0];
        polls++;
    end
    if (!seen)
    begin
        error_count++;
        $display("Factorial run for n = %0d never reported done", n);
    end
endtask

task automatic run_fact(input int n, output logic [soc_pkg::DATA_W-1:0] stat);
    bus_write(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_N), n);
    bus_write(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_GO), 32'd1);
    wait_fact_done(n, stat);
endtask

task automatic test_fact_valid();
    logic [soc_pkg::DATA_W-1:0] stat;
    int                         n;
    for (n = 0; n <= 12; n++)
    begin
        run_fact(n, stat);
        check_word(stat, 32'd1, $sformatf("status for n = %0d", n));
        read_check(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_RES), factorial(n),
                   $sformatf("result for n = %0d", n));
    end
endtask

task automatic test_fact_errors();
    logic [soc_pkg::DATA_W-1:0] stat;
    int                         n;
    // Out of range, done and error together
    for (n = 13; n <= 15; n++)
    begin
        run_fact(n, stat);
        check_word(stat, 32'd3, $sformatf("status for n = %0d", n));
        read_check(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_RES), '0,
                   $sformatf("result for n = %0d", n));
    end
    // Second go during a 12! run, with n changed in between
    bus_write(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_N), 32'd12);
    bus_write(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_GO), 32'd1);
    bus_write(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_N), 32'd3);
    bus_write(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_GO), 32'd1);
    wait_fact_done(12, stat);
    check_word(stat, 32'd1, "status after go while busy");
    read_check(reg_addr(soc_pkg::BLK_FACT, soc_pkg::FACT_RES), factorial(12),
               "result after go while busy");
endtask

//////////////////////////////////////////////////////////////////////
// Seven-segment display
//////////////////////////////////////////////////////////////////////

// Wait for the active-low enable of one digit
task automatic wait_digit(input int d);
    int   waited;
    logic found;
    waited = 0;
    found  = 1'b0;
    while (!found && waited < 8 * soc_pkg::SCAN_DIV + 4)
    begin
        @(negedge clk);
        found = (an == ~(8'b0000_0001 << d));
        waited++;
    end
    if (!found)
    begin
        error_count++;
        $display("Display never enabled digit %0d", d);
    end
endtask

// Caller picks an address whose write lands in the chosen source
task automatic check_display(input logic [1:0]                 src,
                             input logic                       upper,
                             input logic [soc_pkg::ADDR_W-1:0] addr,
                             input logic [soc_pkg::DATA_W-1:0] data);
    logic [31:0] shown;
    logic [15:0] half;
    logic [3:0]  nib;
    int          d;
    @(negedge clk);
    switches = {src, upper, 5'b0_0000};
    // Bus address stays put while the digits are checked
    bus_write(addr, data);
    half  = upper ? data[31:16] : data[15:0];
    shown = {addr[15:0], half};
    for (d = 0; d < 8; d++)
    begin
        wait_digit(d);
        nib = shown[4*d +: 4];
        check_seg(seg, soc_pkg::SEG_TABLE[nib], d);
    end
endtask

`endif

// File: verif/soc_tb.sv
`timescale 1ns/100ps

module soc_tb;

    logic                       clk;
    logic                       rst_n;
    soc_pkg::bus_req_t          bus;
    logic [7:0]                 gpi1;
    logic [7:0]                 gpi2;
    logic [7:0]                 switches;
    logic [soc_pkg::DATA_W-1:0] rdata;
    logic [soc_pkg::DATA_W-1:0] gpo1;
    logic [soc_pkg::DATA_W-1:0] gpo2;
    logic [7:0]                 seg;
    logic [7:0]                 an;

    // Random stream and run bookkeeping
    integer                     seed;
    int                         error_count;
    int                         cycles;

    // Expected RAM contents
    logic [soc_pkg::DATA_W-1:0] ram_model [soc_pkg::RAM_WORDS];

    soc_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus),
        .gpi1     (gpi1),
        .gpi2     (gpi2),
        .switches (switches),
        .rdata    (rdata),
        .gpo1     (gpo1),
        .gpo2     (gpo2),
        .seg      (seg),
        .an       (an)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock and run limit
    //////////////////////////////////////////////////////////////////////

    // 100 ns period
    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // Reset 16, RAM about 200, GPIO about 30, factorial about 350,
    // display about 320 cycles, so 4000 leaves a wide margin
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= 4000)
        begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    `include "soc_tb_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        seed        = 77254;
        error_count = 0;
        cycles      = 0;
        rst_n       = 1'b0;
        bus         = '0;
        gpi1        = 8'h00;
        gpi2        = 8'h00;
        switches    = 8'h00;

        // Hold reset for 16 cycles, release on a falling edge
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_ram();
        test_gpio();
        test_fact_valid();
        test_fact_errors();

        // Upper half of gpo1, written through its own register
        check_display(soc_pkg::DISP_GPO1, 1'b1,
                      reg_addr(soc_pkg::BLK_GPIO, soc_pkg::GPIO_OUT1), 32'hC3A5_1E7D);
        // Lower half of the last write data, here a RAM write
        check_display(soc_pkg::DISP_WDATA, 1'b0, ram_addr(60), 32'h0BAD_F00D);

        $display("Run complete with %0d errors", error_count);
        if (error_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/100ps

module soc_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  soc_pkg::bus_req_t           bus,
    input  logic [7:0]                  gpi1,
    input  logic [7:0]                  gpi2,
    input  logic [7:0]                  switches,
    output logic [soc_pkg::DATA_W-1:0]  rdata,
    output logic [soc_pkg::DATA_W-1:0]  gpo1,
    output logic [soc_pkg::DATA_W-1:0]  gpo2,
    output logic [7:0]                  seg,
    output logic [7:0]                  an
);

    logic                       ram_we;
    logic                       fact_we;
    logic                       gpio_we;
    soc_pkg::rd_sel_t           rd_sel;
    logic [soc_pkg::DATA_W-1:0] ram_rdata;
    logic [soc_pkg::DATA_W-1:0] fact_rdata;
    logic [soc_pkg::DATA_W-1:0] gpio_rdata;

    //////////////////////////////////////////////////////////////////////
    // Decode and memory-mapped blocks
    //////////////////////////////////////////////////////////////////////

    addr_decode u_decode (
        .bus     (bus),
        .ram_we  (ram_we),
        .fact_we (fact_we),
        .gpio_we (gpio_we),
        .rd_sel  (rd_sel)
    );

    data_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .bus   (bus),
        .rdata (ram_rdata)
    );

    fact_accel u_fact (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (fact_we),
        .bus   (bus),
        .rdata (fact_rdata)
    );

    gpio_port u_gpio (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (gpio_we),
        .bus   (bus),
        .gpi1  (gpi1),
        .gpi2  (gpi2),
        .rdata (gpio_rdata),
        .gpo1  (gpo1),
        .gpo2  (gpo2)
    );

    // Debug display watches the bus and the GPIO outputs
    seg_display u_disp (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus),
        .switches (switches),
        .gpo1     (gpo1),
        .gpo2     (gpo2),
        .seg      (seg),
        .an       (an)
    );

    //////////////////////////////////////////////////////////////////////
    // Readback, same cycle as the address
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (rd_sel)
            soc_pkg::SEL_RAM:  rdata = ram_rdata;
            soc_pkg::SEL_FACT: rdata = fact_rdata;
            soc_pkg::SEL_GPIO: rdata = gpio_rdata;
            soc_pkg::SEL_NONE: rdata = '0;
        endcase
    end

endmodule

// File: verilog/seg_display.sv
`timescale 1ns/100ps

module seg_display (
    input  logic                        clk,
    input  logic                        rst_n,
    input  soc_pkg::bus_req_t           bus,
    input  logic [7:0]                  switches,
    input  logic [soc_pkg::DATA_W-1:0]  gpo1,
    input  logic [soc_pkg::DATA_W-1:0]  gpo2,
    output logic [7:0]                  seg,
    output logic [7:0]                  an
);

    logic [soc_pkg::ADDR_W-1:0]           last_addr;
    logic [soc_pkg::DATA_W-1:0]           last_wdata;
    soc_pkg::disp_mode_t                  mode;
    logic [soc_pkg::DATA_W-1:0]           src_word;
    logic [15:0]                          hw_sel;
    logic [15:0]                          hw_reg;
    logic [$clog2(soc_pkg::SCAN_DIV)-1:0] div_cnt;
    logic [2:0]                           digit;
    logic [31:0]                          disp_word;
    logic [3:0]                           nibble;

    //////////////////////////////////////////////////////////////////////
    // Source selection
    //////////////////////////////////////////////////////////////////////

    assign mode = soc_pkg::disp_mode_t'(switches[7:5]);

    always_comb
    begin
        case (mode.src)
            soc_pkg::DISP_GPO1:  src_word = gpo1;
            soc_pkg::DISP_GPO2:  src_word = gpo2;
            soc_pkg::DISP_ADDR:  src_word = last_addr;
            soc_pkg::DISP_WDATA: src_word = last_wdata;
        endcase
    end

    // Upper or lower halfword
    assign hw_sel = mode.upper ? src_word[31:16] : src_word[15:0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            last_addr  <= '0;
            last_wdata <= '0;
            hw_reg     <= '0;
        end
        else
        begin
            // Address tracked every cycle
            last_addr <= bus.addr;
            if (bus.we)
            begin
                last_wdata <= bus.wdata;
            end
            hw_reg <= hw_sel;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Digit scan
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            digit   <= '0;
        end
        else if (int'(div_cnt) == soc_pkg::SCAN_DIV - 1)
        begin
            div_cnt <= '0;
            digit   <= digit + 3'd1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Left four digits show the address, right four the halfword
    assign disp_word = {last_addr[15:0], hw_reg};
    assign nibble    = disp_word[{digit, 2'b00} +: 4];

    // Digit 0 is the rightmost and its enable is active low
    assign an  = ~(8'b0000_0001 << digit);
    assign seg = soc_pkg::SEG_TABLE[nibble];

endmodule

// File: verilog/gpio_port.sv
`timescale 1ns/100ps

module gpio_port (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  soc_pkg::bus_req_t           bus,
    input  logic [7:0]                  gpi1,
    input  logic [7:0]                  gpi2,
    output logic [soc_pkg::DATA_W-1:0]  rdata,
    output logic [soc_pkg::DATA_W-1:0]  gpo1,
    output logic [soc_pkg::DATA_W-1:0]  gpo2
);

    logic [1:0] offset;

    assign offset = bus.addr[3:2];

    // Output registers, inputs have no storage here
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            gpo1 <= '0;
            gpo2 <= '0;
        end
        else if (we)
        begin
            if (offset == soc_pkg::GPIO_OUT1)
            begin
                gpo1 <= bus.wdata;
            end
            if (offset == soc_pkg::GPIO_OUT2)
            begin
                gpo2 <= bus.wdata;
            end
        end
    end

    // Inputs read back zero extended
    always_comb
    begin
        case (offset)
            soc_pkg::GPIO_IN1:  rdata = {{(soc_pkg::DATA_W-8){1'b0}}, gpi1};
            soc_pkg::GPIO_IN2:  rdata = {{(soc_pkg::DATA_W-8){1'b0}}, gpi2};
            soc_pkg::GPIO_OUT1: rdata = gpo1;
            soc_pkg::GPIO_OUT2: rdata = gpo2;
        endcase
    end

endmodule

// File: verilog/fact_accel.sv
`timescale 1ns/100ps

module fact_accel (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  soc_pkg::bus_req_t           bus,
    output logic [soc_pkg::DATA_W-1:0]  rdata
);

    logic [1:0]                 offset;
    logic [3:0]                 n_reg;
    logic [3:0]                 count;
    logic [soc_pkg::DATA_W-1:0] count_ext;
    logic [soc_pkg::DATA_W-1:0] product;
    logic                       busy;
    logic                       done;
    logic                       error;
    logic                       go_wr;
    logic                       start;

    assign offset    = bus.addr[3:2];
    assign count_ext = {{(soc_pkg::DATA_W-4){1'b0}}, count};

    // Go strobe from a write of 1 to the go register
    assign go_wr = we && (offset == soc_pkg::FACT_GO) && bus.wdata[0];
    // Ignored while a run is in flight
    assign start = go_wr && !busy;

    //////////////////////////////////////////////////////////////////////
    // Control and accumulator
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            n_reg   <= '0;
            busy    <= 1'b0;
            done    <= 1'b0;
            error   <= 1'b0;
            product <= '0;
        end
        else
        begin
            if (we && (offset == soc_pkg::FACT_N))
            begin
                n_reg <= bus.wdata[3:0];
            end
            if (start)
            begin
                if (n_reg > soc_pkg::FACT_MAX_N)
                begin
                    // Out of range, finish at once with a zero result
                    done    <= 1'b1;
                    error   <= 1'b1;
                    product <= '0;
                end
                else
                begin
                    busy    <= 1'b1;
                    done    <= 1'b0;
                    error   <= 1'b0;
                    product <= {{(soc_pkg::DATA_W-1){1'b0}}, 1'b1};
                end
            end
            else if (busy)
            begin
                if (count == 4'd0)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                else
                begin
                    // One factor per cycle, n down to 1
                    product <= product * count_ext;
                end
            end
        end
    end

    // Working copy of n
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            count <= n_reg;
        end
        else if (busy && (count != 4'd0))
        begin
            count <= count - 4'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (offset)
            soc_pkg::FACT_N:    rdata = {{(soc_pkg::DATA_W-4){1'b0}}, n_reg};
            soc_pkg::FACT_GO:   rdata = {{(soc_pkg::DATA_W-1){1'b0}}, busy};
            soc_pkg::FACT_STAT: rdata = {{(soc_pkg::DATA_W-2){1'b0}}, error, done};
            soc_pkg::FACT_RES:  rdata = product;
        endcase
    end

    // An error run always reports itself as finished
    a_err_done: assert property (@(posedge clk) disable iff (!rst_n)
        error |-> done);

    // A finished result holds until the next go
    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
        done && !go_wr |=> $stable(product));

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/100ps

module data_ram (
    input  logic                        clk,
    input  logic                        we,
    input  soc_pkg::bus_req_t           bus,
    output logic [soc_pkg::DATA_W-1:0]  rdata
);

    logic [soc_pkg::DATA_W-1:0] mem [soc_pkg::RAM_WORDS];
    logic [soc_pkg::RAM_AW-1:0] word_addr;

    // Word index, byte offset dropped
    assign word_addr = bus.addr[soc_pkg::RAM_AW+1:2];

    // Write on the clock edge
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[word_addr] <= bus.wdata;
        end
    end

    // Read path is combinational
    assign rdata = mem[word_addr];

endmodule

// File: verilog/addr_decode.sv
`timescale 1ns/100ps

module addr_decode (
    input  soc_pkg::bus_req_t bus,
    output logic              ram_we,
    output logic              fact_we,
    output logic              gpio_we,
    output soc_pkg::rd_sel_t  rd_sel
);

    logic       in_window;
    logic [3:0] blk;

    // Only the low 4 KB window is mapped
    assign in_window = (bus.addr[soc_pkg::ADDR_W-1:12] == '0);
    assign blk       = bus.addr[11:8];

    always_comb
    begin
        ram_we  = 1'b0;
        fact_we = 1'b0;
        gpio_we = 1'b0;
        // Unmapped reads fall through to zero
        rd_sel  = soc_pkg::SEL_NONE;
        if (in_window)
        begin
            case (blk)
                soc_pkg::BLK_RAM:
                begin
                    ram_we = bus.we;
                    rd_sel = soc_pkg::SEL_RAM;
                end
                soc_pkg::BLK_FACT:
                begin
                    fact_we = bus.we;
                    rd_sel  = soc_pkg::SEL_FACT;
                end
                soc_pkg::BLK_GPIO:
                begin
                    gpio_we = bus.we;
                    rd_sel  = soc_pkg::SEL_GPIO;
                end
                default:
                begin
                    rd_sel = soc_pkg::SEL_NONE;
                end
            endcase
        end
    end

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths and request
    //////////////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // One processor-side access, write when we is high
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    // Data RAM is word addressed through addr[7:2]
    localparam int RAM_WORDS = 64;
    localparam int RAM_AW    = 6;

    // Block codes compared against addr[11:8]
    localparam logic [3:0] BLK_RAM  = 4'h0;
    localparam logic [3:0] BLK_FACT = 4'h8;
    localparam logic [3:0] BLK_GPIO = 4'h9;

    // Readback source
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_FACT,
        SEL_GPIO,
        SEL_NONE
    } rd_sel_t;

    // Factorial register offsets in addr[3:2]
    localparam logic [1:0] FACT_N    = 2'd0;
    localparam logic [1:0] FACT_GO   = 2'd1;
    localparam logic [1:0] FACT_STAT = 2'd2;
    localparam logic [1:0] FACT_RES  = 2'd3;

    // Largest n whose factorial still fits in 32 bits
    localparam logic [3:0] FACT_MAX_N = 4'd12;

    // GPIO register offsets in addr[3:2]
    localparam logic [1:0] GPIO_IN1  = 2'd0;
    localparam logic [1:0] GPIO_IN2  = 2'd1;
    localparam logic [1:0] GPIO_OUT1 = 2'd2;
    localparam logic [1:0] GPIO_OUT2 = 2'd3;

    //////////////////////////////////////////////////////////////////////
    // Seven-segment display
    //////////////////////////////////////////////////////////////////////

    // Clock cycles per digit, kept short for simulation
    localparam int SCAN_DIV = 16;

    // Mode from switches[7:5]
    typedef struct packed {
        logic [1:0] src;
        logic       upper;
    } disp_mode_t;

    localparam logic [1:0] DISP_GPO1  = 2'd0;
    localparam logic [1:0] DISP_GPO2  = 2'd1;
    localparam logic [1:0] DISP_ADDR  = 2'd2;
    localparam logic [1:0] DISP_WDATA = 2'd3;

    // Active low {dp, g, f, e, d, c, b, a}, dp always off
    localparam logic [7:0] SEG_TABLE [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

endpackage
